//--- Makefile
TOP := csr_unit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f csr_unit.f --top-module csr_unit

# The simulation passes only if the pass line shows up in its output.
sim:
	verilator --binary --timing --assert -f csr_unit.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

//--- csr_unit.f
+incdir+tests
src/riscv_csr_pkg.sv
src/csr_types_pkg.sv
src/trap_sequencer.sv
src/perf_counters.sv
src/machine_csr_regs.sv
src/csr_unit.sv
tests/csr_unit_tb.sv

//--- src/csr_types_pkg.sv
package csr_types_pkg;

  localparam int XLEN       = 32;
  localparam int CSR_ADDR_W = 12;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Width types.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [XLEN-1:0]       cause_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bundles.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // One-cycle request from execute.
  typedef struct packed {
    logic      valid;
    logic      write;
    csr_addr_t addr;
    xlen_t     wdata;
  } csr_req_t;

  // Raw trap sources, before any masking.
  typedef struct packed {
    logic ecall;
    logic illegal;
    logic load_fault;
    logic breakpoint;
    logic int_ext;
    logic int_soft;
    logic int_timer;
  } trap_flags_t;

  typedef struct packed {
    logic   take_trap;
    logic   take_mret;
    cause_t cause;
  } trap_event_t;

  // To fetch.
  typedef struct packed {
    logic  valid;
    xlen_t target;
  } redirect_t;

  typedef enum logic {
    RUN,
    REDIRECT
  } seq_state_t;

endpackage

//--- src/csr_unit.sv
`timescale 1ns/100ps

module csr_unit (
  input  logic                       clock,
  input  logic                       reset,
  input  csr_types_pkg::csr_req_t    csr_req,
  input  logic                       mret,
  input  csr_types_pkg::trap_flags_t flags,
  input  csr_types_pkg::xlen_t       pc,
  input  logic                       retire,
  input  logic                       stall,
  output csr_types_pkg::xlen_t       rdata,
  output csr_types_pkg::redirect_t   redirect
);
  import csr_types_pkg::*;

  trap_event_t trap_event;
  logic        mstatus_mie;
  xlen_t       mie_bits;
  xlen_t       mtvec;
  xlen_t       mepc;
  xlen_t       wdata;
  logic        run_ok;
  logic        retire_ok;
  logic        wr_cycle_lo;
  logic        wr_cycle_hi;
  logic        wr_instret_lo;
  logic        wr_instret_hi;
  logic [63:0] mcycle;
  logic [63:0] minstret;

  assign retire_ok = retire & ~stall & run_ok;  // Only in RUN.

  trap_sequencer i_seq (
    .clock       (clock),
    .reset       (reset),
    .flags       (flags),
    .mret        (mret),
    .mstatus_mie (mstatus_mie),
    .mie_bits    (mie_bits),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .trap_event  (trap_event),
    .retire_ok   (run_ok),
    .redirect    (redirect)
  );

  perf_counters i_counters (
    .clock         (clock),
    .reset         (reset),
    .retire_ok     (retire_ok),
    .wdata         (wdata),
    .wr_cycle_lo   (wr_cycle_lo),
    .wr_cycle_hi   (wr_cycle_hi),
    .wr_instret_lo (wr_instret_lo),
    .wr_instret_hi (wr_instret_hi),
    .mcycle        (mcycle),
    .minstret      (minstret)
  );

  machine_csr_regs i_regs (
    .clock         (clock),
    .reset         (reset),
    .csr_req       (csr_req),
    .trap_event    (trap_event),
    .pc            (pc),
    .flags         (flags),
    .mcycle        (mcycle),
    .minstret      (minstret),
    .rdata         (rdata),
    .mstatus_mie   (mstatus_mie),
    .mie_bits      (mie_bits),
    .mtvec         (mtvec),
    .mepc          (mepc),
    .wr_cycle_lo   (wr_cycle_lo),
    .wr_cycle_hi   (wr_cycle_hi),
    .wr_instret_lo (wr_instret_lo),
    .wr_instret_hi (wr_instret_hi),
    .wdata         (wdata)
  );

endmodule

//--- src/machine_csr_regs.sv
`timescale 1ns/100ps

module machine_csr_regs (
  input  logic                       clock,
  input  logic                       reset,
  input  csr_types_pkg::csr_req_t    csr_req,
  input  csr_types_pkg::trap_event_t trap_event,
  input  csr_types_pkg::xlen_t       pc,
  input  csr_types_pkg::trap_flags_t flags,
  input  logic [63:0]                mcycle,
  input  logic [63:0]                minstret,
  output csr_types_pkg::xlen_t       rdata,
  output logic                       mstatus_mie,
  output csr_types_pkg::xlen_t       mie_bits,
  output csr_types_pkg::xlen_t       mtvec,
  output csr_types_pkg::xlen_t       mepc,
  output logic                       wr_cycle_lo,
  output logic                       wr_cycle_hi,
  output logic                       wr_instret_lo,
  output logic                       wr_instret_hi,
  output csr_types_pkg::xlen_t       wdata
);
  import csr_types_pkg::*;
  import riscv_csr_pkg::*;

  logic   wr_en;
  logic   mpie_q;
  cause_t mcause_q;
  xlen_t  mstatus_rd;
  xlen_t  mip_rd;

  // Writes are dropped in a trap cycle.
  assign wr_en = csr_req.valid & csr_req.write & ~trap_event.take_trap;
  assign wdata = csr_req.wdata;

  // Counter halves live in perf_counters.
  assign wr_cycle_lo   = wr_en & (csr_req.addr == CSR_MCYCLE);
  assign wr_cycle_hi   = wr_en & (csr_req.addr == CSR_MCYCLEH);
  assign wr_instret_lo = wr_en & (csr_req.addr == CSR_MINSTRET);
  assign wr_instret_hi = wr_en & (csr_req.addr == CSR_MINSTRETH);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read side.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    mstatus_rd         = '0;
    mstatus_rd[B_MIE]  = mstatus_mie;
    mstatus_rd[B_MPIE] = mpie_q;

    // mip is the live pending view.
    mip_rd         = '0;
    mip_rd[B_MSIE] = flags.int_soft;
    mip_rd[B_MTIE] = flags.int_timer;
    mip_rd[B_MEIE] = flags.int_ext;
  end

  always_comb begin
    case (csr_req.addr)
      CSR_MSTATUS:             rdata = mstatus_rd;
      CSR_MIE:                 rdata = mie_bits;
      CSR_MTVEC:               rdata = mtvec;
      CSR_MEPC:                rdata = mepc;
      CSR_MCAUSE:              rdata = mcause_q;
      CSR_MIP:                 rdata = mip_rd;
      CSR_MHARTID:             rdata = HART_ID;
      CSR_MCYCLE, CSR_CYCLE:   rdata = mcycle[31:0];
      CSR_MCYCLEH, CSR_CYCLEH: rdata = mcycle[63:32];
      CSR_MINSTRET:            rdata = minstret[31:0];
      CSR_MINSTRETH:           rdata = minstret[63:32];
      default:                 rdata = '0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mstatus_mie <= 1'b0;
      mpie_q      <= 1'b0;
      mie_bits    <= '0;
      mtvec       <= '0;
      mepc        <= '0;
      mcause_q    <= '0;
    end else begin
      if (wr_en) begin
        case (csr_req.addr)
          CSR_MSTATUS: begin
            mstatus_mie <= csr_req.wdata[B_MIE];
            mpie_q      <= csr_req.wdata[B_MPIE];
          end
          CSR_MIE:    mie_bits <= csr_req.wdata;
          CSR_MTVEC:  mtvec    <= csr_req.wdata;
          CSR_MEPC:   mepc     <= csr_req.wdata;
          CSR_MCAUSE: mcause_q <= csr_req.wdata;
          default:    ;  // Read-only or counter.
        endcase
      end

      // Trap entry and mret come last, so they win over a write.
      if (trap_event.take_trap) begin
        mepc        <= pc;
        mcause_q    <= trap_event.cause;
        mpie_q      <= mstatus_mie;
        mstatus_mie <= 1'b0;
      end else if (trap_event.take_mret) begin
        mstatus_mie <= mpie_q;
        mpie_q      <= 1'b1;
      end
    end
  end

  a_trap_xor_mret : assert property (
    @(posedge clock) disable iff (reset) !(trap_event.take_trap && trap_event.take_mret)
  );

endmodule

//--- src/perf_counters.sv
`timescale 1ns/100ps

module perf_counters (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 retire_ok,
  input  csr_types_pkg::xlen_t wdata,
  input  logic                 wr_cycle_lo,
  input  logic                 wr_cycle_hi,
  input  logic                 wr_instret_lo,
  input  logic                 wr_instret_hi,
  output logic [63:0]          mcycle,
  output logic [63:0]          minstret
);
  import csr_types_pkg::*;

  // A half write replaces that half and skips the increment.
  function automatic logic [63:0] next_count(
    input logic [63:0] count,
    input logic        wr_lo,
    input logic        wr_hi,
    input logic        inc,
    input xlen_t       data
  );
    logic [63:0] result;
    result = count;
    if (wr_lo)
      result[31:0] = data;
    else if (wr_hi)
      result[63:32] = data;
    else if (inc)
      result = count + 64'd1;
    return result;
  endfunction

  logic [63:0] mcycle_next;
  logic [63:0] minstret_next;

  assign mcycle_next   = next_count(mcycle, wr_cycle_lo, wr_cycle_hi, 1'b1, wdata);
  assign minstret_next = next_count(minstret, wr_instret_lo, wr_instret_hi,
                                    retire_ok, wdata);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Counter state.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mcycle   <= '0;
      minstret <= '0;
    end else begin
      mcycle   <= mcycle_next;
      minstret <= minstret_next;
    end
  end

  // The address decode upstream selects one half at most.
  a_one_write : assert property (
    @(posedge clock) disable iff (reset)
      $onehot0({wr_cycle_lo, wr_cycle_hi, wr_instret_lo, wr_instret_hi})
  );

endmodule

//--- src/riscv_csr_pkg.sv
package riscv_csr_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Machine and user CSR addresses.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [11:0] CSR_MSTATUS   = 12'h300;
  localparam logic [11:0] CSR_MIE       = 12'h304;
  localparam logic [11:0] CSR_MTVEC     = 12'h305;
  localparam logic [11:0] CSR_MEPC      = 12'h341;
  localparam logic [11:0] CSR_MCAUSE    = 12'h342;
  localparam logic [11:0] CSR_MIP       = 12'h344;
  localparam logic [11:0] CSR_MHARTID   = 12'hF14;

  // Machine counter halves.
  localparam logic [11:0] CSR_MCYCLE    = 12'hB00;
  localparam logic [11:0] CSR_MCYCLEH   = 12'hB80;
  localparam logic [11:0] CSR_MINSTRET  = 12'hB02;
  localparam logic [11:0] CSR_MINSTRETH = 12'hB82;

  // User read-only shadows of mcycle.
  localparam logic [11:0] CSR_CYCLE     = 12'hC00;
  localparam logic [11:0] CSR_CYCLEH    = 12'hC80;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bit positions.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int B_MIE  = 3;   // mstatus.
  localparam int B_MPIE = 7;   // mstatus.

  localparam int B_MSIE = 3;   // Software bit of mie and mip.
  localparam int B_MTIE = 7;   // Timer bit of mie and mip.
  localparam int B_MEIE = 11;  // External bit of mie and mip.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // mcause codes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [31:0] CAUSE_ILLEGAL    = 32'd2;
  localparam logic [31:0] CAUSE_BREAK      = 32'd3;
  localparam logic [31:0] CAUSE_LOAD_FAULT = 32'd5;
  localparam logic [31:0] CAUSE_ECALL      = 32'd11;

  // Interrupt codes are or'ed with the interrupt flag.
  localparam logic [31:0] CAUSE_INT_SOFT   = 32'd3;
  localparam logic [31:0] CAUSE_INT_TIMER  = 32'd7;
  localparam logic [31:0] CAUSE_INT_EXT    = 32'd11;

  localparam logic [31:0] CAUSE_INT_FLAG   = 32'h8000_0000;

  // Single hart.
  localparam logic [31:0] HART_ID = 32'h0000_0000;

endpackage

//--- src/trap_sequencer.sv
`timescale 1ns/100ps

module trap_sequencer (
  input  logic                       clock,
  input  logic                       reset,
  input  csr_types_pkg::trap_flags_t flags,
  input  logic                       mret,
  input  logic                       mstatus_mie,
  input  csr_types_pkg::xlen_t       mie_bits,
  input  csr_types_pkg::xlen_t       mtvec,
  input  csr_types_pkg::xlen_t       mepc,
  output csr_types_pkg::trap_event_t trap_event,
  output logic                       retire_ok,
  output csr_types_pkg::redirect_t   redirect
);
  import csr_types_pkg::*;
  import riscv_csr_pkg::*;

  seq_state_t state;
  seq_state_t state_next;
  logic       in_run;
  logic       int_timer;
  logic       int_soft;
  logic       int_ext;
  logic       any_exc;
  logic       take_trap;
  logic       take_mret;
  cause_t     cause;
  logic       redirect_valid;
  xlen_t      redirect_target;

  assign in_run    = (state == RUN);
  assign retire_ok = in_run;  // No counting while the pipeline flushes.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Source ranking.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    int_timer = mstatus_mie & mie_bits[B_MTIE] & flags.int_timer;
    int_soft  = mstatus_mie & mie_bits[B_MSIE] & flags.int_soft;
    int_ext   = mstatus_mie & mie_bits[B_MEIE] & flags.int_ext;
    any_exc   = flags.breakpoint | flags.load_fault | flags.illegal | flags.ecall;

    // Interrupts first, then exceptions.
    if (int_timer)
      cause = CAUSE_INT_FLAG | CAUSE_INT_TIMER;
    else if (int_soft)
      cause = CAUSE_INT_FLAG | CAUSE_INT_SOFT;
    else if (int_ext)
      cause = CAUSE_INT_FLAG | CAUSE_INT_EXT;
    else if (flags.breakpoint)
      cause = CAUSE_BREAK;
    else if (flags.load_fault)
      cause = CAUSE_LOAD_FAULT;
    else if (flags.illegal)
      cause = CAUSE_ILLEGAL;
    else
      cause = CAUSE_ECALL;
  end

  assign take_trap  = in_run & (int_timer | int_soft | int_ext | any_exc);
  assign take_mret  = in_run & mret & ~take_trap;  // A trap wins.
  assign trap_event = '{take_trap: take_trap, take_mret: take_mret, cause: cause};

  always_comb begin
    case (state)
      RUN:      state_next = (take_trap | take_mret) ? REDIRECT : RUN;
      REDIRECT: state_next = RUN;
      default:  state_next = RUN;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Registered redirect.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state          <= RUN;
      redirect_valid <= 1'b0;
    end else begin
      state          <= state_next;
      redirect_valid <= take_trap | take_mret;
    end
  end

  // Target takes mtvec or mepc before this edge's update.
  always_ff @(posedge clock) begin
    if (take_trap)
      redirect_target <= {mtvec[XLEN-1:2], 2'b00};
    else if (take_mret)
      redirect_target <= mepc;
  end

  assign redirect = '{valid: redirect_valid, target: redirect_target};

  a_redirect_single : assert property (
    @(posedge clock) disable iff (reset) redirect.valid |=> !redirect.valid
  );

endmodule

//--- tests/csr_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expected CSR state, counters and sequencer state.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
logic        exp_in_redirect = 1'b0;
logic        exp_mie         = 1'b0;  // mstatus.MIE.
logic        exp_mpie        = 1'b0;
xlen_t       exp_ie          = '0;    // The mie register.
xlen_t       exp_mtvec       = '0;
xlen_t       exp_mepc        = '0;
cause_t      exp_mcause      = '0;
logic [63:0] exp_mcycle      = '0;
logic [63:0] exp_minstret    = '0;
redirect_t   exp_redirect    = '0;

function automatic xlen_t expected_read(input csr_addr_t addr, input trap_flags_t f);
  xlen_t value;
  value = '0;
  case (addr)
    CSR_MSTATUS: begin
      value[B_MIE]  = exp_mie;
      value[B_MPIE] = exp_mpie;
    end
    CSR_MIP: begin
      value[B_MSIE] = f.int_soft;
      value[B_MTIE] = f.int_timer;
      value[B_MEIE] = f.int_ext;
    end
    CSR_MIE:                 value = exp_ie;
    CSR_MTVEC:               value = exp_mtvec;
    CSR_MEPC:                value = exp_mepc;
    CSR_MCAUSE:              value = exp_mcause;
    CSR_MHARTID:             value = HART_ID;
    CSR_MCYCLE, CSR_CYCLE:   value = exp_mcycle[31:0];
    CSR_MCYCLEH, CSR_CYCLEH: value = exp_mcycle[63:32];
    CSR_MINSTRET:            value = exp_minstret[31:0];
    CSR_MINSTRETH:           value = exp_minstret[63:32];
    default:                 value = '0;
  endcase
  return value;
endfunction

// Interrupts need MIE and their own enable bit. Exceptions always trap.
task automatic rank_sources(input trap_flags_t f, output logic take, output cause_t cause);
  take = 1'b1;
  if (exp_mie && exp_ie[B_MTIE] && f.int_timer)
    cause = CAUSE_INT_FLAG | CAUSE_INT_TIMER;
  else if (exp_mie && exp_ie[B_MSIE] && f.int_soft)
    cause = CAUSE_INT_FLAG | CAUSE_INT_SOFT;
  else if (exp_mie && exp_ie[B_MEIE] && f.int_ext)
    cause = CAUSE_INT_FLAG | CAUSE_INT_EXT;
  else if (f.breakpoint)
    cause = CAUSE_BREAK;
  else if (f.load_fault)
    cause = CAUSE_LOAD_FAULT;
  else if (f.illegal)
    cause = CAUSE_ILLEGAL;
  else if (f.ecall)
    cause = CAUSE_ECALL;
  else begin
    take  = 1'b0;
    cause = '0;
  end
endtask

// Advances the expected state across one rising clock edge.
task automatic model_step(input csr_req_t req, input logic do_mret, input trap_flags_t f,
                          input xlen_t cur_pc, input logic do_retire, input logic do_stall);
  logic   trap;
  logic   ret;
  logic   wr;
  logic   old_mie;
  logic   old_mpie;
  logic   cycle_wr;
  logic   instret_wr;
  cause_t cause;
  xlen_t  old_mtvec;
  xlen_t  old_mepc;
  rank_sources(f, trap, cause);
  trap       = trap & ~exp_in_redirect;  // Sources are ignored while flushing.
  ret        = do_mret & ~exp_in_redirect & ~trap;
  wr         = req.valid & req.write & ~trap;
  old_mie    = exp_mie;
  old_mpie   = exp_mpie;
  old_mtvec  = exp_mtvec;
  old_mepc   = exp_mepc;
  cycle_wr   = 1'b0;
  instret_wr = 1'b0;
  if (wr) begin
    case (req.addr)
      CSR_MSTATUS: begin
        exp_mie  = req.wdata[B_MIE];
        exp_mpie = req.wdata[B_MPIE];
      end
      CSR_MIE:    exp_ie     = req.wdata;
      CSR_MTVEC:  exp_mtvec  = req.wdata;
      CSR_MEPC:   exp_mepc   = req.wdata;
      CSR_MCAUSE: exp_mcause = req.wdata;
      CSR_MCYCLE: begin
        exp_mcycle[31:0] = req.wdata;
        cycle_wr         = 1'b1;
      end
      CSR_MCYCLEH: begin
        exp_mcycle[63:32] = req.wdata;
        cycle_wr          = 1'b1;
      end
      CSR_MINSTRET: begin
        exp_minstret[31:0] = req.wdata;
        instret_wr         = 1'b1;
      end
      CSR_MINSTRETH: begin
        exp_minstret[63:32] = req.wdata;
        instret_wr          = 1'b1;
      end
      default: ;
    endcase
  end
  if (!cycle_wr)
    exp_mcycle = exp_mcycle + 64'd1;
  if (!instret_wr && do_retire && !do_stall && !exp_in_redirect)
    exp_minstret = exp_minstret + 64'd1;
  if (trap) begin
    exp_mepc   = cur_pc;
    exp_mcause = cause;
    exp_mpie   = old_mie;
    exp_mie    = 1'b0;
    exp_redirect.target = {old_mtvec[31:2], 2'b00};
  end else if (ret) begin
    exp_mie  = old_mpie;
    exp_mpie = 1'b1;
    exp_redirect.target = old_mepc;
  end
  exp_redirect.valid = trap | ret;
  exp_in_redirect    = trap | ret;
endtask

//--- tests/csr_unit_tb.sv
`timescale 1ns/100ps

module csr_unit_tb;
  import csr_types_pkg::*;
  import riscv_csr_pkg::*;

  localparam int          CLK_PERIOD   = 20;
  localparam int          RESET_CYCLES = 3;
  localparam int          NUM_CYCLES   = 3000;
  localparam logic [31:0] SEED         = 32'hca17_b3d8;
  localparam csr_addr_t   KNOWN_ADDRS [13] = '{
    CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MIP, CSR_MHARTID,
    CSR_MCYCLE, CSR_MCYCLEH, CSR_MINSTRET, CSR_MINSTRETH, CSR_CYCLE, CSR_CYCLEH
  };

  logic        clock;
  logic        reset;
  csr_req_t    csr_req;
  logic        mret;
  trap_flags_t flags;
  xlen_t       pc;
  logic        retire;
  logic        stall;
  xlen_t       rdata;
  redirect_t   redirect;
  int unsigned errors;
  int unsigned checks;

  `include "csr_model.svh"

  csr_unit i_dut (
    .clock    (clock),
    .reset    (reset),
    .csr_req  (csr_req),
    .mret     (mret),
    .flags    (flags),
    .pc       (pc),
    .retire   (retire),
    .stall    (stall),
    .rdata    (rdata),
    .redirect (redirect)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // Room for the reset and a few spare cycles.
  initial begin
    #((NUM_CYCLES + 10) * CLK_PERIOD);
    $display("Watchdog expired before the random cycles were done, the run hung.");
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic chance(input int unsigned percent);
    return ($urandom % 100) < percent;
  endfunction

  task automatic drive_random();
    csr_req_t    r;
    trap_flags_t f;
    logic [31:0] rnd;
    int unsigned idx;
    f.ecall      = chance(5);
    f.illegal    = chance(5);
    f.load_fault = chance(5);
    f.breakpoint = chance(5);
    f.int_ext    = chance(5);
    f.int_soft   = chance(5);
    f.int_timer  = chance(5);
    r.valid      = chance(50);
    r.write      = chance(50);
    rnd          = $urandom;
    if (chance(85)) begin
      idx    = $urandom % 13;
      r.addr = KNOWN_ADDRS[idx[3:0]];
    end else begin
      r.addr = rnd[11:0];  // Mostly unmapped.
    end
    r.wdata = $urandom;
    rnd     = $urandom;
    csr_req <= r;
    flags   <= f;
    pc      <= {rnd[31:2], 2'b00};
    mret    <= chance(5);
    retire  <= chance(60);
    stall   <= chance(20);
  endtask

  task automatic check_outputs();
    xlen_t expected;
    expected = expected_read(csr_req.addr, flags);
    checks   = checks + 1;
    if (rdata !== expected) begin
      errors = errors + 1;
      $display("Fail at %0t: rdata (addr %h) expected %h, actual %h",
               $time, csr_req.addr, expected, rdata);
    end
    if (redirect.valid !== exp_redirect.valid) begin
      errors = errors + 1;
      $display("Fail at %0t: redirect.valid expected %b, actual %b",
               $time, exp_redirect.valid, redirect.valid);
    end
    if (exp_redirect.valid && redirect.target !== exp_redirect.target) begin
      errors = errors + 1;
      $display("Fail at %0t: redirect.target expected %h, actual %h",
               $time, exp_redirect.target, redirect.target);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus and checks, one cycle at a time.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    void'($urandom(SEED));
    errors  = 0;
    checks  = 0;
    reset   = 1'b1;
    csr_req = '0;
    mret    = 1'b0;
    flags   = '0;
    pc      = '0;
    retire  = 1'b0;
    stall   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    drive_random();
    for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
      @(negedge clock);  // Outputs have settled and inputs hold until the next edge.
      check_outputs();
      model_step(csr_req, mret, flags, pc, retire, stall);
      @(posedge clock);
      drive_random();
    end
    $display("Checked %0d cycles, %0d errors.", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
